// ==== all.f ====
+incdir+include
rtl/exec_isa_pkg.sv
rtl/exec_bus_pkg.sv
rtl/exec_alu.sv
rtl/exec_branch.sv
rtl/exec_lsu.sv
rtl/exec_fib.sv
rtl/exec_retire.sv
rtl/execute.sv
dv/tb_execute.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing -f all.f --top-module tb_execute \
    -Mdir obj_dir -o tb_execute > build.log 2>&1 \
    && ./obj_dir/tb_execute > sim.log 2>&1 \
    || { cat build.log; [ -f sim.log ] && cat sim.log; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0

// ==== dv/tb_execute.sv ====
`include "exec_params.svh"

module tb_execute;
    timeunit 1ns;
    timeprecision 1ps;

    import exec_isa_pkg::*;
    import exec_bus_pkg::*;

    localparam int N_ALU = 200;
    localparam int N_BR  = 150;
    localparam int N_LSU = 150;
    localparam int N_EXC = 200;
    localparam int N_FIB = 12;
    // Reset, one cycle per plain instruction, Fibonacci allowance with stalls, margin
    localparam int WATCHDOG_CYCLES = 8 + N_ALU + N_BR + N_LSU + N_EXC + N_FIB * (70 + 3) + 50;

    logic clk = 1'b0;
    logic reset_n;
    logic stall_i;
    logic illegal_i;
    exec_issue_t issue_i;

    logic [`EXEC_XLEN-1:0]   result_o;
    logic [`EXEC_REG_AW-1:0] rd_o;
    logic                    write_enable_o;
    exec_op_e                op_o;
    mem_req_t                mem_req_o;
    logic                    hold_o;
    logic                    jump_o;
    logic [`EXEC_XLEN-1:0]   jump_target_o;
    logic                    raise_exception_o;
    exc_code_e               exception_code_o;

    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     tests = 0;

    // Model outputs for the instruction being presented
    logic [31:0]     exp_result;
    logic            exp_has_result;
    logic            exp_jump;
    logic [31:0]     exp_target;
    exc_code_e       exp_code;
    logic            exp_we;
    logic            exp_is_mem;
    logic            exp_read_en;
    logic [3:0]      exp_be;
    logic [31:0]     exp_addr;
    logic [31:0]     exp_wdata;

    execute dut_i (
        .clk               (clk),
        .reset_n           (reset_n),
        .stall_i           (stall_i),
        .illegal_i         (illegal_i),
        .issue_i           (issue_i),
        .result_o          (result_o),
        .rd_o              (rd_o),
        .write_enable_o    (write_enable_o),
        .op_o              (op_o),
        .mem_req_o         (mem_req_o),
        .hold_o            (hold_o),
        .jump_o            (jump_o),
        .jump_target_o     (jump_target_o),
        .raise_exception_o (raise_exception_o),
        .exception_code_o  (exception_code_o)
    );

    always #50 clk = ~clk;

    task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: got %08h, expected %08h", name, act, exp);
        end
    endtask

    function automatic logic [31:0] fib_model(input logic [`EXEC_FIB_NW-1:0] n);
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] t;
        x = '0;
        y = 32'd1;
        for (int i = 0; i < int'(n); i++) begin
            t = x + y;
            x = y;
            y = t;
        end
        return x;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    task automatic predict(input exec_issue_t ins, input logic ill);
        logic [31:0] a;
        logic [31:0] b;
        logic        is_load;
        logic        is_store;
        logic        is_branch;
        logic        lmis;
        logic        smis;
        a = ins.rs1_data;
        b = ins.operand_b;
        exp_addr  = a + b;
        is_load   = ins.op inside {LB, LBU, LH, LHU, LW};
        is_store  = ins.op inside {SB, SH, SW};
        is_branch = ins.op inside {BEQ, BNE, BLT, BLTU, BGE, BGEU};
        exp_has_result = ins.op inside {[ADD:AUIPC], JAL, JALR, FIB};
        case (ins.op)
            ADD:       exp_result = a + b;
            SUB:       exp_result = a - b;
            AND:       exp_result = a & b;
            OR:        exp_result = a | b;
            XOR:       exp_result = a ^ b;
            SLL:       exp_result = a << b[4:0];
            SRL:       exp_result = a >> b[4:0];
            SRA:       exp_result = 32'($signed(a) >>> b[4:0]);
            SLT:       exp_result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:      exp_result = (a < b) ? 32'd1 : 32'd0;
            LUI:       exp_result = b;
            AUIPC:     exp_result = ins.imm_target;
            JAL, JALR: exp_result = ins.pc_next;
            FIB:       exp_result = fib_model(a[`EXEC_FIB_NW-1:0]);
            default:   exp_result = exp_addr;
        endcase
        case (ins.op)
            BEQ:       exp_jump = (a == b);
            BNE:       exp_jump = (a != b);
            BLT:       exp_jump = $signed(a) < $signed(b);
            BGE:       exp_jump = $signed(a) >= $signed(b);
            BLTU:      exp_jump = a < b;
            BGEU:      exp_jump = a >= b;
            JAL, JALR: exp_jump = 1'b1;
            default:   exp_jump = 1'b0;
        endcase
        exp_target = (ins.op == JALR) ? {exp_addr[31:1], 1'b0} : ins.imm_target;
        exp_is_mem  = is_load || is_store;
        exp_read_en = is_load;
        case (ins.op)
            SB:      exp_be = 4'b0001 << exp_addr[1:0];
            SH:      exp_be = 4'b0011 << exp_addr[1:0];
            SW:      exp_be = 4'b1111;
            default: exp_be = 4'b0000;
        endcase
        case (ins.op)
            SB:      exp_wdata = {4{ins.rs2_data[7:0]}};
            SH:      exp_wdata = {2{ins.rs2_data[15:0]}};
            default: exp_wdata = ins.rs2_data;
        endcase
        lmis = ((ins.op inside {LH, LHU}) && exp_addr[0]) || ((ins.op == LW) && exp_addr[1:0] != 0);
        smis = ((ins.op == SH) && exp_addr[0]) || ((ins.op == SW) && exp_addr[1:0] != 0);
        if (ins.op == NOP)                  exp_code = EXC_NONE;
        else if (ill)                       exp_code = EXC_ILLEGAL;
        else if (exp_jump && exp_target[1]) exp_code = EXC_IADDR_MISALIGNED;
        else if (ins.op == ECALL)           exp_code = EXC_ECALL_M;
        else if (ins.op == EBREAK)          exp_code = EXC_BREAKPOINT;
        else if (lmis)                      exp_code = EXC_LADDR_MISALIGNED;
        else if (smis)                      exp_code = EXC_SADDR_MISALIGNED;
        else                                exp_code = EXC_NONE;
        exp_we = (ins.rd != 0) && (ins.op != NOP) && !is_store && !is_branch
              && (exp_code == EXC_NONE);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic pick_op(input int first, input int count, output exec_op_e op);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        op = exec_op_e'(6'(first + r % count));
    endtask

    task automatic make_issue(input exec_op_e op, output exec_issue_t ins);
        ins.op         = op;
        ins.rs1_data   = $random(seed);
        ins.rs2_data   = $random(seed);
        ins.operand_b  = $random(seed);
        ins.rd         = 5'($random(seed));
        ins.pc_next    = $random(seed);
        ins.imm_target = $random(seed);
        // Equal operands now and then so eq and ge branches go both ways
        if (($random(seed) & 3) == 0) ins.operand_b = ins.rs1_data;
        if (($random(seed) & 7) == 0) ins.rd = '0;
    endtask

    // Present one instruction on a falling edge, return on the falling edge after it retires
    task automatic run_instr(input exec_issue_t ins, input logic ill);
        int waited;
        int exp_waited;
        waited     = 0;
        exp_waited = (ins.op == FIB) ? int'(ins.rs1_data[`EXEC_FIB_NW-1:0]) : 0;
        issue_i   = ins;
        illegal_i = ill;
        predict(ins, ill);
        #1;
        check("jump_o", 32'(jump_o), 32'(exp_jump));
        if (exp_jump) check("jump_target_o", jump_target_o, exp_target);
        check("exception_code_o", 32'(exception_code_o), 32'(exp_code));
        check("raise_exception_o", 32'(raise_exception_o), 32'(exp_code != EXC_NONE));
        check("hold_o", 32'(hold_o), 32'(ins.op == FIB));
        @(negedge clk);
        while (hold_o && waited <= exp_waited) begin
            waited++;
            @(negedge clk);
        end
        // Hold spans n+1 cycles, the first one seen at presentation
        check("hold_o cycles", 32'(waited), 32'(exp_waited));
        if (ins.op == FIB) @(negedge clk);
        check("op_o", 32'(op_o), 32'(ins.op));
        check("rd_o", 32'(rd_o), 32'(ins.rd));
        check("write_enable_o", 32'(write_enable_o), 32'(exp_we));
        if (exp_has_result) check("result_o", result_o, exp_result);
        check("mem_req_o.read_en", 32'(mem_req_o.read_en), 32'(exp_read_en));
        check("mem_req_o.write_en", 32'(mem_req_o.write_en), 32'(exp_be));
        if (exp_is_mem) check("mem_req_o.addr", mem_req_o.addr, exp_addr);
        if (exp_be != 0) check("mem_req_o.write_data", mem_req_o.write_data, exp_wdata);
    endtask

    // Random instructions under stall must leave every registered output alone
    task automatic stall_cycles(input int n);
        exec_issue_t ins;
        exec_op_e    op;
        logic [31:0] res;
        logic [31:0] rd;
        logic [31:0] we;
        logic [31:0] op_q;
        mem_req_t    req;
        res  = result_o;
        rd   = 32'(rd_o);
        we   = 32'(write_enable_o);
        op_q = 32'(op_o);
        req  = mem_req_o;
        stall_i = 1'b1;
        for (int k = 0; k < n; k++) begin
            pick_op(1, 20, op);
            make_issue(op, ins);
            issue_i = ins;
            @(negedge clk);
            check("result_o", result_o, res);
            check("rd_o", 32'(rd_o), rd);
            check("write_enable_o", 32'(write_enable_o), we);
            check("op_o", 32'(op_o), op_q);
            check("mem_req_o.addr", mem_req_o.addr, req.addr);
            check("mem_req_o.write_data", mem_req_o.write_data, req.write_data);
            check("mem_req_o.read_en", 32'(mem_req_o.read_en), 32'(req.read_en));
            check("mem_req_o.write_en", 32'(mem_req_o.write_en), 32'(req.write_en));
        end
        stall_i = 1'b0;
    endtask

    task automatic finish_test(input string name, input int n, input int err_start);
        tests++;
        $display("test %-9s %0d instructions, %0d errors", name, n, errors - err_start);
    endtask

    task automatic run_test(input string name, input int first, input int count, input int n,
                            input int ill_pct);
        exec_issue_t ins;
        exec_op_e    op;
        logic        ill;
        int          err_start;
        err_start = errors;
        for (int k = 0; k < n; k++) begin
            pick_op(first, count, op);
            make_issue(op, ins);
            ill = (($random(seed) & 32'h7fff_ffff) % 100) < ill_pct;
            run_instr(ins, ill);
        end
        finish_test(name, n, err_start);
    endtask

    initial begin
        exec_issue_t ins;
        int          err_start;
        seed      = 32'hff97_97f1;
        reset_n   = 1'b0;
        stall_i   = 1'b0;
        illegal_i = 1'b0;
        issue_i   = '0;
        repeat (8) @(negedge clk);
        reset_n = 1'b1;

        err_start = errors;
        check("write_enable_o", 32'(write_enable_o), 32'd0);
        check("mem_req_o.read_en", 32'(mem_req_o.read_en), 32'd0);
        check("mem_req_o.write_en", 32'(mem_req_o.write_en), 32'd0);
        check("op_o", 32'(op_o), 32'(NOP));
        finish_test("reset", 0, err_start);

        run_test("alu", 1, 12, N_ALU, 0);
        run_test("branch", 21, 8, N_BR, 0);
        run_test("lsu", 13, 8, N_LSU, 0);
        run_test("exception", 0, 31, N_EXC, 30);

        err_start = errors;
        for (int k = 0; k < N_FIB; k++) begin
            make_issue(FIB, ins);
            run_instr(ins, 1'b0);
            stall_cycles(1 + (($random(seed) & 32'h7fff_ffff) % 3));
        end
        finish_test("fib_stall", N_FIB, err_start);

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 100);
        $display("watchdog expired, the DUT never finished the sequence");
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== rtl/execute.sv ====
`include "exec_params.svh"

module execute (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      stall_i,
    input  logic                      illegal_i,
    input  exec_bus_pkg::exec_issue_t issue_i,
    output logic [`EXEC_XLEN-1:0]     result_o,
    output logic [`EXEC_REG_AW-1:0]   rd_o,
    output logic                      write_enable_o,
    output exec_isa_pkg::exec_op_e    op_o,
    output exec_bus_pkg::mem_req_t    mem_req_o,
    output logic                      hold_o,
    output logic                      jump_o,
    output logic [`EXEC_XLEN-1:0]     jump_target_o,
    output logic                      raise_exception_o,
    output exec_isa_pkg::exc_code_e   exception_code_o
);
    import exec_bus_pkg::*;

    logic [`EXEC_XLEN-1:0] sum;
    logic [`EXEC_XLEN-1:0] alu_result;
    logic [`EXEC_XLEN-1:0] fib_result;
    alu_flags_t            flags;
    branch_t               branch;
    logic                  load_misaligned;
    logic                  store_misaligned;
    logic                  fib_hold;
    logic                  accept;

    exec_alu u_alu (
        .issue_i  (issue_i),
        .sum_o    (sum),
        .result_o (alu_result),
        .flags_o  (flags)
    );

    exec_branch u_branch (
        .issue_i  (issue_i),
        .flags_i  (flags),
        .sum_i    (sum),
        .branch_o (branch)
    );

    exec_lsu u_lsu (
        .clk                (clk),
        .reset_n            (reset_n),
        .stall_i            (stall_i),
        .issue_i            (issue_i),
        .sum_i              (sum),
        .mem_req_o          (mem_req_o),
        .load_misaligned_o  (load_misaligned),
        .store_misaligned_o (store_misaligned)
    );

    exec_fib u_fib (
        .clk          (clk),
        .reset_n      (reset_n),
        .stall_i      (stall_i),
        .accept_i     (accept),
        .issue_i      (issue_i),
        .fib_result_o (fib_result),
        .hold_o       (fib_hold)
    );

    exec_retire u_retire (
        .clk                (clk),
        .reset_n            (reset_n),
        .stall_i            (stall_i),
        .illegal_i          (illegal_i),
        .issue_i            (issue_i),
        .alu_result_i       (alu_result),
        .fib_result_i       (fib_result),
        .branch_i           (branch),
        .load_misaligned_i  (load_misaligned),
        .store_misaligned_i (store_misaligned),
        .fib_hold_i         (fib_hold),
        .accept_o           (accept),
        .hold_o             (hold_o),
        .raise_exception_o  (raise_exception_o),
        .exception_code_o   (exception_code_o),
        .result_o           (result_o),
        .rd_o               (rd_o),
        .write_enable_o     (write_enable_o),
        .op_o               (op_o)
    );

    // Branch decision goes straight out to fetch
    assign jump_o        = branch.jump;
    assign jump_target_o = branch.target;

endmodule

// ==== rtl/exec_retire.sv ====
`include "exec_params.svh"

module exec_retire (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      stall_i,
    input  logic                      illegal_i,
    input  exec_bus_pkg::exec_issue_t issue_i,
    input  logic [`EXEC_XLEN-1:0]     alu_result_i,
    input  logic [`EXEC_XLEN-1:0]     fib_result_i,
    input  exec_bus_pkg::branch_t     branch_i,
    input  logic                      load_misaligned_i,
    input  logic                      store_misaligned_i,
    input  logic                      fib_hold_i,
    output logic                      accept_o,
    output logic                      hold_o,
    output logic                      raise_exception_o,
    output exec_isa_pkg::exc_code_e   exception_code_o,
    output logic [`EXEC_XLEN-1:0]     result_o,
    output logic [`EXEC_REG_AW-1:0]   rd_o,
    output logic                      write_enable_o,
    output exec_isa_pkg::exec_op_e    op_o
);
    import exec_isa_pkg::*;

    logic [`EXEC_XLEN-1:0] result;
    logic                  write_enable;
    logic                  no_writeback;

    assign hold_o   = fib_hold_i;
    assign accept_o = !hold_o && !stall_i;

    always_comb begin
        case (issue_i.op)
            FIB:       result = fib_result_i;
            JAL, JALR: result = issue_i.pc_next;
            default:   result = alu_result_i;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Exceptions, highest priority first
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (issue_i.op == NOP)             exception_code_o = EXC_NONE;
        else if (illegal_i)                exception_code_o = EXC_ILLEGAL;
        else if (branch_i.misaligned)      exception_code_o = EXC_IADDR_MISALIGNED;
        else if (issue_i.op == ECALL)      exception_code_o = EXC_ECALL_M;
        else if (issue_i.op == EBREAK)     exception_code_o = EXC_BREAKPOINT;
        else if (load_misaligned_i)        exception_code_o = EXC_LADDR_MISALIGNED;
        else if (store_misaligned_i)       exception_code_o = EXC_SADDR_MISALIGNED;
        else                               exception_code_o = EXC_NONE;
    end

    assign raise_exception_o = exception_code_o != EXC_NONE;

    // Stores and branches never write the register file
    assign no_writeback = issue_i.op inside {NOP, SB, SH, SW, BEQ, BNE, BLT, BLTU, BGE, BGEU};
    assign write_enable = (issue_i.rd != '0) && !no_writeback && !hold_o && !raise_exception_o;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            write_enable_o <= 1'b0;
            op_o           <= NOP;
        end else if (!stall_i) begin
            write_enable_o <= write_enable;
            op_o           <= issue_i.op;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            result_o <= result;
            rd_o     <= issue_i.rd;
        end
    end

endmodule

// ==== rtl/exec_fib.sv ====
`include "exec_params.svh"

module exec_fib (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      stall_i,
    input  logic                      accept_i,
    input  exec_bus_pkg::exec_issue_t issue_i,
    output logic [`EXEC_XLEN-1:0]     fib_result_o,
    output logic                      hold_o
);
    import exec_isa_pkg::*;

    typedef enum logic [1:0] {FIB_IDLE, FIB_RUN, FIB_DONE} fib_state_e;

    fib_state_e              state;
    logic [`EXEC_FIB_NW-1:0] count;
    logic [`EXEC_XLEN-1:0]   term_a;
    logic [`EXEC_XLEN-1:0]   term_b;
    logic                    is_fib;
    logic                    start;
    logic                    done;
    logic                    finished;

    assign is_fib = issue_i.op == FIB;
    // Finished flag stops a second run of the same instruction
    assign start  = is_fib && (state != FIB_RUN) && !finished && !stall_i;
    assign done   = (state == FIB_RUN) && (count == '0);
    assign hold_o = is_fib && !(done || finished);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= FIB_IDLE;
            count    <= '0;
            finished <= 1'b0;
        end else begin
            case (state)
                FIB_IDLE, FIB_DONE: begin
                    if (start) begin
                        state <= FIB_RUN;
                        count <= issue_i.rs1_data[`EXEC_FIB_NW-1:0];
                    end
                end
                FIB_RUN: begin
                    if (done) begin
                        state <= FIB_DONE;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                default: state <= FIB_IDLE;
            endcase
            if (accept_i) begin
                finished <= 1'b0;
            end else if (done) begin
                finished <= 1'b1;
            end
        end
    end

    // term_a walks F(0), F(1), ... and wraps at the data width
    always_ff @(posedge clk) begin
        if (start) begin
            term_a <= '0;
            term_b <= `EXEC_XLEN'd1;
        end else if ((state == FIB_RUN) && !done) begin
            term_a <= term_b;
            term_b <= term_a + term_b;
        end
    end

    assign fib_result_o = term_a;

endmodule

// ==== rtl/exec_lsu.sv ====
`include "exec_params.svh"

module exec_lsu (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      stall_i,
    input  exec_bus_pkg::exec_issue_t issue_i,
    input  logic [`EXEC_XLEN-1:0]     sum_i,
    output exec_bus_pkg::mem_req_t    mem_req_o,
    output logic                      load_misaligned_o,
    output logic                      store_misaligned_o
);
    import exec_isa_pkg::*;

    logic                  read_en;
    logic [`EXEC_BE_W-1:0] write_en;
    logic [`EXEC_XLEN-1:0] write_data;

    logic                  read_en_q;
    logic [`EXEC_BE_W-1:0] write_en_q;
    logic [`EXEC_XLEN-1:0] addr_q;
    logic [`EXEC_XLEN-1:0] write_data_q;

    assign read_en = issue_i.op inside {LB, LBU, LH, LHU, LW};

    // Lanes picked by the low address bits
    always_comb begin
        case (issue_i.op)
            SB:      write_en = `EXEC_BE_W'(1) << sum_i[1:0];
            SH:      write_en = `EXEC_BE_W'(3) << sum_i[1:0];
            SW:      write_en = '1;
            default: write_en = '0;
        endcase
    end

    // Narrow stores repeat the data on every lane
    always_comb begin
        case (issue_i.op)
            SB:      write_data = {4{issue_i.rs2_data[7:0]}};
            SH:      write_data = {2{issue_i.rs2_data[15:0]}};
            default: write_data = issue_i.rs2_data;
        endcase
    end

    assign load_misaligned_o  = ((issue_i.op inside {LH, LHU}) && sum_i[0])
                             || ((issue_i.op == LW) && (sum_i[1:0] != 2'b00));
    assign store_misaligned_o = ((issue_i.op == SH) && sum_i[0])
                             || ((issue_i.op == SW) && (sum_i[1:0] != 2'b00));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            read_en_q  <= 1'b0;
            write_en_q <= '0;
        end else if (!stall_i) begin
            read_en_q  <= read_en;
            write_en_q <= write_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            addr_q       <= sum_i;
            write_data_q <= write_data;
        end
    end

    assign mem_req_o = '{addr: addr_q, read_en: read_en_q, write_en: write_en_q,
                         write_data: write_data_q};

endmodule

// ==== rtl/exec_branch.sv ====
`include "exec_params.svh"

module exec_branch (
    input  exec_bus_pkg::exec_issue_t issue_i,
    input  exec_bus_pkg::alu_flags_t  flags_i,
    input  logic [`EXEC_XLEN-1:0]     sum_i,
    output exec_bus_pkg::branch_t     branch_o
);
    import exec_isa_pkg::*;

    always_comb begin
        case (issue_i.op)
            BEQ:       branch_o.jump = flags_i.equal;
            BNE:       branch_o.jump = !flags_i.equal;
            BLT:       branch_o.jump = flags_i.lt;
            BLTU:      branch_o.jump = flags_i.ltu;
            BGE:       branch_o.jump = !flags_i.lt;
            BGEU:      branch_o.jump = !flags_i.ltu;
            JAL, JALR: branch_o.jump = 1'b1;
            default:   branch_o.jump = 1'b0;
        endcase
    end

    // JALR target comes from rs1 plus offset, low bit dropped
    assign branch_o.target = (issue_i.op == JALR) ? {sum_i[`EXEC_XLEN-1:1], 1'b0}
                                                  : issue_i.imm_target;

    // No compressed instructions, so any taken target off a word boundary traps
    assign branch_o.misaligned = branch_o.jump && branch_o.target[1];

endmodule

// ==== rtl/exec_alu.sv ====
`include "exec_params.svh"

module exec_alu (
    input  exec_bus_pkg::exec_issue_t issue_i,
    output logic [`EXEC_XLEN-1:0]     sum_o,
    output logic [`EXEC_XLEN-1:0]     result_o,
    output exec_bus_pkg::alu_flags_t  flags_o
);
    import exec_isa_pkg::*;

    logic [`EXEC_XLEN-1:0] add_b;
    logic [4:0]            shamt;

    // Subtraction reuses the adder with a negated operand
    assign add_b = (issue_i.op == SUB) ? -issue_i.operand_b : issue_i.operand_b;
    assign sum_o = issue_i.rs1_data + add_b;
    assign shamt = issue_i.operand_b[4:0];

    assign flags_o.equal = issue_i.rs1_data == issue_i.operand_b;
    assign flags_o.lt    = $signed(issue_i.rs1_data) < $signed(issue_i.operand_b);
    assign flags_o.ltu   = issue_i.rs1_data < issue_i.operand_b;

    //////////////////////////////////////////////////////////////////////
    // Result select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (issue_i.op)
            AND:     result_o = issue_i.rs1_data & issue_i.operand_b;
            OR:      result_o = issue_i.rs1_data | issue_i.operand_b;
            XOR:     result_o = issue_i.rs1_data ^ issue_i.operand_b;
            SLL:     result_o = issue_i.rs1_data << shamt;
            SRL:     result_o = issue_i.rs1_data >> shamt;
            SRA:     result_o = $signed(issue_i.rs1_data) >>> shamt;
            SLT:     result_o = {{(`EXEC_XLEN-1){1'b0}}, flags_o.lt};
            SLTU:    result_o = {{(`EXEC_XLEN-1){1'b0}}, flags_o.ltu};
            // Upper immediate arrives already shifted
            LUI:     result_o = issue_i.operand_b;
            AUIPC:   result_o = issue_i.imm_target;
            default: result_o = sum_o;
        endcase
    end

endmodule

// ==== rtl/exec_bus_pkg.sv ====
`include "exec_params.svh"

package exec_bus_pkg;

    // Instruction as handed over by the decode stage
    typedef struct packed {
        exec_isa_pkg::exec_op_e    op;
        logic [`EXEC_XLEN-1:0]     rs1_data;
        logic [`EXEC_XLEN-1:0]     rs2_data;
        // Immediate or rs2, already selected by decode
        logic [`EXEC_XLEN-1:0]     operand_b;
        logic [`EXEC_REG_AW-1:0]   rd;
        logic [`EXEC_XLEN-1:0]     pc_next;
        logic [`EXEC_XLEN-1:0]     imm_target;
    } exec_issue_t;

    // Data memory request
    typedef struct packed {
        logic [`EXEC_XLEN-1:0]     addr;
        logic                      read_en;
        logic [`EXEC_BE_W-1:0]     write_en;
        logic [`EXEC_XLEN-1:0]     write_data;
    } mem_req_t;

    // Compare results of rs1 against operand_b
    typedef struct packed {
        logic equal;
        logic lt;
        logic ltu;
    } alu_flags_t;

    typedef struct packed {
        logic                      jump;
        logic [`EXEC_XLEN-1:0]     target;
        logic                      misaligned;
    } branch_t;

endpackage

// ==== rtl/exec_isa_pkg.sv ====
package exec_isa_pkg;

    // Operations decoded upstream and executed here
    typedef enum logic [5:0] {
        NOP,
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        LUI,
        AUIPC,
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW,
        BEQ,
        BNE,
        BLT,
        BLTU,
        BGE,
        BGEU,
        JAL,
        JALR,
        ECALL,
        EBREAK,
        FIB
    } exec_op_e;

    // Machine cause numbers, EXC_NONE sits outside the standard range
    typedef enum logic [4:0] {
        EXC_IADDR_MISALIGNED = 5'd0,
        EXC_ILLEGAL          = 5'd2,
        EXC_BREAKPOINT       = 5'd3,
        EXC_LADDR_MISALIGNED = 5'd4,
        EXC_SADDR_MISALIGNED = 5'd6,
        EXC_ECALL_M          = 5'd11,
        EXC_NONE             = 5'd31
    } exc_code_e;

endpackage

// ==== include/exec_params.svh ====
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// Datapath width
`define EXEC_XLEN   32

// Register file address width
`define EXEC_REG_AW 5

// One write enable per byte lane
`define EXEC_BE_W   4

// Low rs1 bits taken as the Fibonacci index
`define EXEC_FIB_NW 6

`endif
